//--- vlog.f
+incdir+include
hdl/rram_pkg.sv
hdl/rram_instr_sequencer.sv
hdl/rram_row_driver.sv
hdl/rram_column_driver.sv
hdl/rram_adc_readout.sv
hdl/rram_ctrl_top.sv
test/rram_ctrl_tb.sv

//--- test/rram_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rram_params.svh"

module rram_ctrl_tb;
    import rram_pkg::*;

    localparam int TIMEOUT      = 1000;   // Cycles per wait loop
    localparam int MODE_NONE    = 0;
    localparam int MODE_STORE   = 1;
    localparam int MODE_COMPUTE = 2;

    logic                    CLK;
    logic                    RESET_ACC;
    logic                    instr_valid;
    logic                    instr_ready;
    instr_t                  instr_data;
    logic                    din_valid;
    logic                    din_ready;
    word_t                   din_data;
    logic                    dout_valid;
    logic                    dout_ready;
    word_t                   dout_data;
    therm_t                  adc_therm [`RRAM_NUM_ADC];
    logic [`RRAM_NUM_WL-1:0] wl_sel;
    line_drive_t             bl_sel [`RRAM_NUM_SL];
    line_drive_t             sl_sel [`RRAM_NUM_SL];
    logic [`RRAM_NUM_SL-1:0] sl_mux_sel;
    logic                    bias_write;

    therm_t   therm_table [`RRAM_NUM_ADC][`RRAM_COLS_PER_ADC];   // Crossbar model ADC codes
    acc_t     acc_model [`RRAM_NUM_ADC];                         // Expected accumulators
    word_t    exp_q [$];                                         // Expected dout words
    int       err_count   = 0;
    int       check_total = 0;
    int       words_seen  = 0;
    int       busy_cycles = 0;
    int       prog_cycles = 0;
    int       comp_cycles = 0;
    int       mode        = MODE_NONE;
    logic     hold_back   = 1'b0;   // Random dout back-pressure
    wl_addr_t st_row;
    logic [1:0] st_base;
    word_t    st_words [2];
    logic [1:0] cp_seg;
    word_t    cp_word;

    rram_ctrl_top i_rram_ctrl_top (
        .CLK         (CLK),
        .RESET_ACC   (RESET_ACC),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_data  (instr_data),
        .din_valid   (din_valid),
        .din_ready   (din_ready),
        .din_data    (din_data),
        .dout_valid  (dout_valid),
        .dout_ready  (dout_ready),
        .dout_data   (dout_data),
        .adc_therm   (adc_therm),
        .wl_sel      (wl_sel),
        .bl_sel      (bl_sel),
        .sl_sel      (sl_sel),
        .sl_mux_sel  (sl_mux_sel),
        .bias_write  (bias_write)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;   // 10 ns period
    end

    // Reference models
    function automatic int count_set_bits(therm_t code);
        int n;
        n = 0;
        for (int b = 0; b < `RRAM_THERM_W; b++) begin
            n += code[b];
        end
        return n;
    endfunction

    // {bl, sl} for a programmed column
    function automatic logic [5:0] drive_pair(logic w, logic pol);
        if (!pol) return {1'b0, ~w, w, 1'b0, w, ~w};
        else return {1'b0, w, ~w, 1'b0, ~w, w};
    endfunction

    function automatic word_t expected_read_word(int idx);
        word_t w;
        int    c;
        w = '0;
        for (int n = 0; n < 8; n++) begin
            c = idx * 8 + n;   // Lowest column in lowest nibble
            w[n*4 +: 4] = 4'(count_set_bits(therm_table[c / 16][c % 16]));
        end
        return w;
    endfunction

    function automatic int adc_sum(int a, int last_off);
        int s;
        s = 0;
        for (int o = 0; o <= last_off; o++) begin
            s += count_set_bits(therm_table[a][o]);
        end
        return s;
    endfunction

    function automatic logic [`RRAM_NUM_WL-1:0] seg_pattern(logic [1:0] seg, word_t w);
        logic [`RRAM_NUM_WL-1:0] p;
        int                      base;
        p    = '0;
        base = (seg * 64) % `RRAM_NUM_WL;   // 7-bit row address wraps
        for (int i = 0; i < 32; i++) begin
            p[base + 2*i]     = w[i];    // True input
            p[base + 2*i + 1] = ~w[i];   // Complement
        end
        return p;
    endfunction

    function automatic logic [`RRAM_NUM_SL-1:0] mux_pattern(int off);
        logic [`RRAM_NUM_SL-1:0] p;
        p = '0;
        for (int a = 0; a < `RRAM_NUM_ADC; a++) begin
            p[a*16 + off] = 1'b1;
        end
        return p;
    endfunction

    function automatic instr_t make_instr(logic [3:0] code, logic [15:0] opc);
        return instr_t'({code, opc});
    endfunction

    // Compare tasks
    task automatic check_word(word_t got, word_t exp, string what);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_drive(line_drive_t got, line_drive_t exp, string what);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_sel(logic [`RRAM_NUM_WL-1:0] got, logic [`RRAM_NUM_WL-1:0] exp,
                             string what);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        check_total++;
        if (got != exp) begin
            err_count++;
            $display("ERROR %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic stall_abort(string what);
        $display("Timeout: the %s stream made no progress for %0d cycles", what, TIMEOUT);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Stimulus tasks start and end on a falling edge
    task automatic send_instr(instr_t ins);
        int cnt;
        cnt = 0;
        instr_valid = 1'b1;
        instr_data  = ins;
        while (!instr_ready && cnt < TIMEOUT) begin
            @(negedge CLK);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            stall_abort("instruction");
        end else begin
            @(negedge CLK);   // Taken at the rising edge in between
            instr_valid = 1'b0;
        end
    endtask

    task automatic send_data(word_t w);
        int cnt;
        cnt = 0;
        din_valid = 1'b1;
        din_data  = w;
        while (!din_ready && cnt < TIMEOUT) begin
            @(negedge CLK);
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            stall_abort("data-in");
        end else begin
            @(negedge CLK);
            din_valid = 1'b0;   // Next call raises it again in the same step
        end
    endtask

    // Back in IDLE with every expected word consumed
    task automatic wait_idle(string what);
        int cnt;
        cnt = 0;
        while ((exp_q.size() != 0 || !instr_ready) && cnt < TIMEOUT) begin
            @(negedge CLK);
            cnt++;
        end
        if (cnt >= TIMEOUT) stall_abort(what);
    endtask

    task automatic fill_table();
        int k;
        for (int a = 0; a < `RRAM_NUM_ADC; a++) begin
            for (int o = 0; o < `RRAM_COLS_PER_ADC; o++) begin
                k = $urandom_range(15, 0);
                therm_table[a][o] = therm_t'((16'd1 << k) - 16'd1);   // k ones from bit 0
            end
        end
    endtask

    task automatic end_test(int num, string name, int errs_before);
        $display("Test %0d (%s) finished, %0d errors", num, name, err_count - errs_before);
    endtask

    task automatic run_compute(logic clear, logic [1:0] seg, logic [3:0] cb);
        word_t w;
        w = $urandom();
        fill_table();
        for (int a = 0; a < `RRAM_NUM_ADC; a++) begin
            acc_model[a] = clear ? acc_t'(adc_sum(a, cb)) : acc_model[a] + acc_t'(adc_sum(a, cb));
        end
        for (int j = 0; j < 4; j++) begin
            exp_q.push_back({acc_model[2*j+1], acc_model[2*j]});   // Lower index in low half
        end
        cp_seg      = seg;
        cp_word     = w;
        comp_cycles = 0;
        mode        = MODE_COMPUTE;
        fork
            send_instr(make_instr(4'b0111, {8'd0, 1'b1, clear, cb, seg}));
            send_data(w);
        join
        wait_idle("data-out");
        mode = MODE_NONE;
        check_count(comp_cycles, cb + 1, "compute cycles");
    endtask

    // Crossbar model drives one code per ADC from the selected mux offset
    initial begin : crossbar_model
        for (int a = 0; a < `RRAM_NUM_ADC; a++) adc_therm[a] = '0;
        forever begin
            @(negedge CLK);
            for (int a = 0; a < `RRAM_NUM_ADC; a++) begin
                adc_therm[a] = '0;   // Nothing selected
                for (int o = 0; o < `RRAM_COLS_PER_ADC; o++) begin
                    if (sl_mux_sel[a*16 + o]) adc_therm[a] = therm_table[a][o];
                end
            end
        end
    end

    // Output sink and compare
    initial begin : compare_out
        word_t exp;
        dout_ready = 1'b0;
        forever begin
            @(negedge CLK);
            dout_ready = hold_back ? ($urandom_range(2, 0) != 0) : 1'b1;
            if (dout_valid && dout_ready) begin   // Transfers at the next rising edge
                words_seen++;
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("ERROR %0t ns: unexpected dout word %h", $time, dout_data);
                end else begin
                    exp = exp_q.pop_front();
                    check_word(dout_data, exp, "dout_data");
                end
            end
        end
    end

    // Line drive checks during program and compute cycles
    initial begin : line_monitor
        int k;
        int col0;
        logic [5:0] pair;
        logic [`RRAM_NUM_WL-1:0] one_row;
        forever begin
            @(negedge CLK);
            if (mode == MODE_STORE) begin
                if (!instr_ready) busy_cycles++;
                if (wl_sel != '0 && prog_cycles < 16) begin
                    k       = prog_cycles / 8;   // Packet
                    one_row = '0;
                    one_row[st_row] = 1'b1;
                    check_sel(wl_sel, one_row, "program wl_sel");
                    check_flag(bias_write, 1'b1, "bias_write");
                    col0 = ((st_base + k) * 32) % `RRAM_NUM_SL;
                    for (int c = 0; c < `RRAM_NUM_SL; c++) begin
                        if (c >= col0 && c < col0 + 32) begin
                            pair = drive_pair(st_words[k][c - col0], 1'(prog_cycles % 2));
                        end else begin
                            pair = 6'b100100;   // Reference on both lines
                        end
                        check_drive(bl_sel[c], pair[5:3], "program bl_sel");
                        check_drive(sl_sel[c], pair[2:0], "program sl_sel");
                    end
                    prog_cycles++;
                end else if (wl_sel != '0) begin
                    err_count++;
                    $display("ERROR %0t ns: program pulse beyond the expected 16", $time);
                end
            end else if (mode == MODE_COMPUTE && sl_mux_sel != '0) begin
                check_sel(wl_sel, seg_pattern(cp_seg, cp_word), "compute wl_sel");
                check_sel(sl_mux_sel, mux_pattern(comp_cycles % 16), "compute sl_mux_sel");
                comp_cycles++;
            end
        end
    end

    initial begin : main
        int e0;
        void'($urandom(32'hc0fe2021));
        RESET_ACC   = 1'b1;
        instr_valid = 1'b0;
        instr_data  = '0;
        din_valid   = 1'b0;
        din_data    = '0;
        for (int a = 0; a < `RRAM_NUM_ADC; a++) acc_model[a] = '0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET_ACC = 1'b0;

        // Test 1 checks the reset state
        e0 = err_count;
        check_flag(instr_ready, 1'b1, "instr_ready");
        check_flag(din_ready, 1'b0, "din_ready");
        check_flag(dout_valid, 1'b0, "dout_valid");
        check_flag(bias_write, 1'b0, "reset bias_write");
        check_sel(wl_sel, '0, "wl_sel");
        check_sel(sl_mux_sel, '0, "sl_mux_sel");
        for (int c = 0; c < `RRAM_NUM_SL; c++) begin
            check_drive(bl_sel[c], 3'b100, "reset bl_sel");
            check_drive(sl_sel[c], 3'b100, "reset sl_sel");
        end
        end_test(1, "reset state", e0);

        // Test 2 stores two packets with din_valid held high throughout
        e0          = err_count;
        st_row      = wl_addr_t'($urandom());
        st_base     = 2'($urandom());
        st_words[0] = $urandom();
        st_words[1] = $urandom();
        busy_cycles = 0;
        prog_cycles = 0;
        mode        = MODE_STORE;
        fork
            send_instr(make_instr(4'b0100, {5'd0, 2'd1, st_base, st_row}));
            begin
                send_data(st_words[0]);
                send_data(st_words[1]);
            end
        join
        wait_idle("instruction");
        @(negedge CLK);   // Last program command trails the return to IDLE
        mode = MODE_NONE;
        check_count(busy_cycles, 2 * (1 + 8), "store busy cycles");
        check_count(prog_cycles, 16, "program cycles");
        end_test(2, "store", e0);

        // Test 3 reads four packets under random back-pressure
        e0 = err_count;
        fill_table();
        for (int k = 0; k < 16; k++) exp_q.push_back(expected_read_word(k));
        words_seen = 0;
        hold_back  = 1'b1;
        send_instr(make_instr(4'b0101, {5'd0, 2'd3, 2'd0, 7'($urandom())}));
        wait_idle("data-out");
        hold_back = 1'b0;
        check_count(words_seen, 16, "read words");
        end_test(3, "read", e0);

        // Test 4 computes with clear and readout
        e0 = err_count;
        run_compute(1'b1, 2'($urandom()), 4'd5);
        end_test(4, "compute with clear", e0);

        // Test 5 sends an unknown code, then a compute that adds to the previous sums
        e0 = err_count;
        send_instr(make_instr(4'b1111, 16'($urandom())));
        repeat (3) begin
            check_flag(instr_ready, 1'b1, "instr_ready after unknown code");
            check_flag(din_ready, 1'b0, "din_ready after unknown code");
            check_flag(dout_valid, 1'b0, "dout_valid after unknown code");
            check_sel(wl_sel, '0, "wl_sel after unknown code");
            @(negedge CLK);
        end
        run_compute(1'b0, 2'($urandom()), 4'd9);
        end_test(5, "accumulate", e0);

        $display("Tests run: 5, checks: %0d, errors: %0d", check_total, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/rram_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rram_params.svh"

module rram_ctrl_top (
    input  logic                     CLK,
    input  logic                     RESET_ACC,
    input  logic                     instr_valid,
    output logic                     instr_ready,
    input  rram_pkg::instr_t         instr_data,
    input  logic                     din_valid,
    output logic                     din_ready,
    input  rram_pkg::word_t          din_data,
    output logic                     dout_valid,
    input  logic                     dout_ready,
    output rram_pkg::word_t          dout_data,
    input  rram_pkg::therm_t         adc_therm [`RRAM_NUM_ADC],
    output logic [`RRAM_NUM_WL-1:0]  wl_sel,
    output rram_pkg::line_drive_t    bl_sel [`RRAM_NUM_SL],
    output rram_pkg::line_drive_t    sl_sel [`RRAM_NUM_SL],
    output logic [`RRAM_NUM_SL-1:0]  sl_mux_sel,
    output logic                     bias_write
);
    import rram_pkg::*;

    // Registered command and operands, shared by all drivers
    local_cmd_e  cmd;
    wl_addr_t    row_addr;
    col_start_t  col_start;
    col_offset_t col_offset;
    logic        col_pol;
    logic        clear_acc;
    word_t       load_word;
    read_index_t read_index;

    rram_instr_sequencer i_sequencer (
        .CLK         (CLK),
        .RESET_ACC   (RESET_ACC),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_data  (instr_data),
        .din_valid   (din_valid),
        .din_ready   (din_ready),
        .din_data    (din_data),
        .dout_valid  (dout_valid),
        .dout_ready  (dout_ready),
        .cmd         (cmd),
        .row_addr    (row_addr),
        .col_start   (col_start),
        .col_offset  (col_offset),
        .col_pol     (col_pol),
        .clear_acc   (clear_acc),
        .bias_write  (bias_write),
        .load_word   (load_word),
        .read_index  (read_index)
    );

    rram_row_driver i_row_driver (
        .CLK       (CLK),
        .RESET_ACC (RESET_ACC),
        .cmd       (cmd),
        .row_addr  (row_addr),
        .load_word (load_word),
        .wl_sel    (wl_sel)
    );

    rram_column_driver i_column_driver (
        .CLK        (CLK),
        .RESET_ACC  (RESET_ACC),
        .cmd        (cmd),
        .col_start  (col_start),
        .col_offset (col_offset),
        .col_pol    (col_pol),
        .load_word  (load_word),
        .bl_sel     (bl_sel),
        .sl_sel     (sl_sel),
        .sl_mux_sel (sl_mux_sel)
    );

    rram_adc_readout i_adc_readout (
        .CLK        (CLK),
        .RESET_ACC  (RESET_ACC),
        .cmd        (cmd),
        .col_offset (col_offset),
        .read_index (read_index),
        .clear_acc  (clear_acc),
        .adc_therm  (adc_therm),
        .dout_data  (dout_data)
    );

endmodule

`default_nettype wire

//--- hdl/rram_adc_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "rram_params.svh"

module rram_adc_readout (
    input  logic                     CLK,
    input  logic                     RESET_ACC,
    input  rram_pkg::local_cmd_e     cmd,
    input  rram_pkg::col_offset_t    col_offset,
    input  rram_pkg::read_index_t    read_index,
    input  logic                     clear_acc,
    input  rram_pkg::therm_t         adc_therm [`RRAM_NUM_ADC],
    output rram_pkg::word_t          dout_data
);
    import rram_pkg::*;

    localparam int RES_PER_WORD = `RRAM_DATA_W / `RRAM_ADC_W;   // 8 nibbles
    localparam int ACC_PER_WORD = `RRAM_DATA_W / `RRAM_ACC_W;   // 2 halves

    adc_code_t adc_bin [`RRAM_NUM_ADC];   // Converted ADC values
    adc_code_t result  [`RRAM_NUM_SL];    // Last read row, one code per column
    acc_t      acc     [`RRAM_NUM_ADC];   // Partial Hamming distance per class

    // Thermometer to binary, count of set bits
    always_comb begin
        for (int a = 0; a < `RRAM_NUM_ADC; a++) begin
            adc_bin[a] = adc_code_t'($countones(adc_therm[a]));
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            for (int c = 0; c < `RRAM_NUM_SL; c++) begin
                result[c] <= '0;
            end
            for (int a = 0; a < `RRAM_NUM_ADC; a++) begin
                acc[a] <= '0;
            end
        end else begin
            for (int a = 0; a < `RRAM_NUM_ADC; a++) begin
                if (cmd == CMD_READ_SINGLE) begin
                    result[a*`RRAM_COLS_PER_ADC + col_offset] <= adc_bin[a];
                end
                if (clear_acc) begin
                    acc[a] <= '0;
                end else if (cmd == CMD_COMPUTE) begin
                    acc[a] <= acc[a] + acc_t'(adc_bin[a]);   // Wraps
                end
            end
        end
    end

    always_comb begin
        dout_data = '0;
        case (cmd)
            CMD_READ_ADC_OUT: begin
                // Lowest column in lowest nibble
                for (int n = 0; n < RES_PER_WORD; n++) begin
                    dout_data[n*`RRAM_ADC_W +: `RRAM_ADC_W] = result[read_index*RES_PER_WORD + n];
                end
            end
            CMD_READ_ACC_OUT: begin
                for (int n = 0; n < ACC_PER_WORD; n++) begin
                    dout_data[n*`RRAM_ACC_W +: `RRAM_ACC_W] =
                        acc[read_index[1:0]*ACC_PER_WORD + n];
                end
            end
            default: begin
                dout_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rram_column_driver.sv
`timescale 1ns/1ps
`default_nettype none

`include "rram_params.svh"

module rram_column_driver (
    input  logic                     CLK,
    input  logic                     RESET_ACC,
    input  rram_pkg::local_cmd_e     cmd,
    input  rram_pkg::col_start_t     col_start,
    input  rram_pkg::col_offset_t    col_offset,
    input  logic                     col_pol,
    input  rram_pkg::word_t          load_word,
    output rram_pkg::line_drive_t    bl_sel [`RRAM_NUM_SL],
    output rram_pkg::line_drive_t    sl_sel [`RRAM_NUM_SL],
    output logic [`RRAM_NUM_SL-1:0]  sl_mux_sel
);
    import rram_pkg::*;

    localparam line_drive_t LINE_REF   = 3'b100;
    localparam line_drive_t LINE_PLUS  = 3'b001;
    localparam line_drive_t LINE_FLOAT = 3'b000;
    localparam logic [`RRAM_NUM_SL-1:0] WORD_MASK = {`RRAM_DATA_W{1'b1}};

    logic [`RRAM_NUM_SL-1:0] weight_reg;
    logic [`RRAM_NUM_SL-1:0] col_sel_n;   // Low = column takes part in programming
    logic                    pw;          // Weight after polarity swap

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            weight_reg <= '0;
            col_sel_n  <= '1;
        end else if (cmd == CMD_WRITE_WEIGHTS) begin
            // One data word lands at col_start, rest cleared and unselected
            weight_reg <= `RRAM_NUM_SL'(load_word) << col_start;
            col_sel_n  <= ~(WORD_MASK << col_start);
        end
    end

    always_comb begin
        pw         = 1'b0;
        sl_mux_sel = '0;
        for (int i = 0; i < `RRAM_NUM_SL; i++) begin
            bl_sel[i] = LINE_REF;
            sl_sel[i] = LINE_REF;
        end
        case (cmd)
            CMD_PROGRAM: begin
                for (int i = 0; i < `RRAM_NUM_SL; i++) begin
                    pw = weight_reg[i] ^ col_pol;   // Pol 1 swaps BL and SL sense
                    if (!col_sel_n[i]) begin
                        bl_sel[i] = {1'b0, ~pw, pw};
                        sl_sel[i] = {1'b0, pw, ~pw};
                    end
                end
            end
            CMD_READ_SINGLE, CMD_COMPUTE: begin
                for (int a = 0; a < `RRAM_NUM_ADC; a++) begin
                    bl_sel[a*`RRAM_COLS_PER_ADC + col_offset] = LINE_PLUS;
                    sl_sel[a*`RRAM_COLS_PER_ADC + col_offset] = LINE_FLOAT;   // SL charges ADC cap
                    sl_mux_sel[a*`RRAM_COLS_PER_ADC +: `RRAM_COLS_PER_ADC] =
                        `RRAM_COLS_PER_ADC'(1) << col_offset;
                end
            end
            default: begin
                sl_mux_sel = '0;   // All lines at reference
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rram_row_driver.sv
`timescale 1ns/1ps
`default_nettype none

`include "rram_params.svh"

module rram_row_driver (
    input  logic                     CLK,
    input  logic                     RESET_ACC,
    input  rram_pkg::local_cmd_e     cmd,
    input  rram_pkg::wl_addr_t       row_addr,
    input  rram_pkg::word_t          load_word,
    output logic [`RRAM_NUM_WL-1:0]  wl_sel
);
    import rram_pkg::*;

    // One compute step covers every input and its complement
    localparam int SEG_W = 2 * `RRAM_DATA_W;
    localparam logic [`RRAM_NUM_WL-1:0] SEG_MASK = {SEG_W{1'b1}};

    logic [`RRAM_NUM_WL-1:0] in_reg;   // Differential inputs, even line true, odd line inverted

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            in_reg <= '0;
        end else if (cmd == CMD_WRITE_INPUTS) begin
            for (int i = 0; i < `RRAM_DATA_W; i++) begin
                in_reg[row_addr + 2*i]     <= load_word[i];
                in_reg[row_addr + 2*i + 1] <= ~load_word[i];
            end
        end
    end

    always_comb begin
        wl_sel = '0;
        case (cmd)
            CMD_PROGRAM, CMD_READ_SINGLE: wl_sel[row_addr] = 1'b1;   // Single row
            CMD_COMPUTE: wl_sel = in_reg & (SEG_MASK << row_addr);     // Whole segment
            default: wl_sel = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rram_instr_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rram_params.svh"

module rram_instr_sequencer (
    input  logic                   CLK,
    input  logic                   RESET_ACC,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  rram_pkg::instr_t       instr_data,
    input  logic                   din_valid,
    output logic                   din_ready,
    input  rram_pkg::word_t        din_data,
    output logic                   dout_valid,
    input  logic                   dout_ready,
    output rram_pkg::local_cmd_e   cmd,
    output rram_pkg::wl_addr_t     row_addr,
    output rram_pkg::col_start_t   col_start,
    output rram_pkg::col_offset_t  col_offset,
    output logic                   col_pol,
    output logic                   clear_acc,
    output logic                   bias_write,
    output rram_pkg::word_t        load_word,
    output rram_pkg::read_index_t  read_index
);
    import rram_pkg::*;

    localparam logic [2:0] PROG_LAST = 3'(2 * `RRAM_WRITE_PULSES - 1);   // Last program cycle
    localparam logic [3:0] OFFS_LAST = 4'(`RRAM_COLS_PER_ADC - 1);       // Full mux sweep

    typedef enum logic [2:0] {S_IDLE, S_LOAD, S_PROG, S_SWEEP, S_OUT} step_e;

    step_e       state;
    logic [4:0]  step;         // STORE uses {packet, pulse}, others use low nibble
    instr_code_e op_q;         // Instruction being executed
    logic [1:0]  base_q;       // STORE column packet base
    logic [1:0]  burst_q;      // STORE last packet
    logic [3:0]  sweep_last;   // Last column offset of a sweep
    logic [3:0]  out_last;     // Last output word
    read_index_t idx_base;     // First output word index
    logic        rdout_q;      // COMPUTE readout enable

    assign instr_ready = (state == S_IDLE);
    assign din_ready   = (state == S_LOAD);

    always_ff @(posedge CLK) begin
        if (RESET_ACC) begin
            state      <= S_IDLE;
            step       <= '0;
            cmd        <= CMD_IDLE;
            dout_valid <= 1'b0;
            clear_acc  <= 1'b0;
            bias_write <= 1'b0;
        end else begin
            clear_acc <= 1'b0;   // Pulse only
            case (state)
                S_IDLE: begin
                    cmd        <= CMD_IDLE;
                    bias_write <= 1'b0;
                    step       <= '0;
                    if (instr_valid) begin
                        op_q    <= instr_data.code;
                        base_q  <= instr_data.opcode[8:7];
                        burst_q <= instr_data.opcode[10:9];
                        row_addr <= instr_data.opcode[6:0];
                        case (instr_data.code)
                            STORE_RRAM: begin
                                bias_write <= 1'b1;   // Write bias for the whole store
                                state      <= S_LOAD;
                            end
                            READ_RRAM: begin
                                sweep_last <= OFFS_LAST;
                                out_last   <= {instr_data.opcode[10:9], 2'b11};  // 4 words/packet
                                idx_base   <= {instr_data.opcode[8:7], 2'b00};
                                state      <= S_SWEEP;
                            end
                            HAM_SEG_COMPUTE: begin
                                // 64 lines per segment
                                row_addr   <= wl_addr_t'({instr_data.opcode[1:0], 6'd0});
                                sweep_last <= instr_data.opcode[5:2];
                                clear_acc  <= instr_data.opcode[6];
                                rdout_q    <= instr_data.opcode[7];
                                out_last   <= 4'd3;   // 8 accumulators, 2 per word
                                idx_base   <= '0;
                                state      <= S_LOAD;
                            end
                            default: begin
                                state <= S_IDLE;   // Unknown code, accepted and dropped
                            end
                        endcase
                    end
                end
                S_LOAD: begin
                    cmd <= CMD_IDLE;   // Nothing on the lines while waiting for data
                    if (din_valid) begin
                        load_word <= din_data;
                        col_start <= {base_q + step[4:3], 5'd0};   // 32 columns per packet
                        if (op_q == STORE_RRAM) begin
                            cmd   <= CMD_WRITE_WEIGHTS;
                            state <= S_PROG;
                        end else begin
                            cmd   <= CMD_WRITE_INPUTS;
                            state <= S_SWEEP;
                        end
                    end
                end
                S_PROG: begin
                    cmd     <= CMD_PROGRAM;
                    col_pol <= step[0];   // Alternates, starts at 0
                    step    <= step + 1'b1;
                    if (step[2:0] == PROG_LAST) begin
                        state <= (step[4:3] == burst_q) ? S_IDLE : S_LOAD;
                    end
                end
                S_SWEEP: begin
                    cmd        <= (op_q == READ_RRAM) ? CMD_READ_SINGLE : CMD_COMPUTE;
                    col_offset <= step[3:0];
                    if (step[3:0] == sweep_last) begin
                        step  <= '0;
                        state <= (op_q == READ_RRAM || rdout_q) ? S_OUT : S_IDLE;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                S_OUT: begin
                    if (!dout_valid) begin
                        // Last sample lands this edge, first word valid next cycle
                        cmd        <= (op_q == READ_RRAM) ? CMD_READ_ADC_OUT : CMD_READ_ACC_OUT;
                        read_index <= idx_base;
                        dout_valid <= 1'b1;
                    end else if (dout_ready) begin
                        if (step[3:0] == out_last) begin
                            dout_valid <= 1'b0;
                            cmd        <= CMD_IDLE;
                            state      <= S_IDLE;
                        end else begin
                            step       <= step + 1'b1;
                            read_index <= read_index + 1'b1;   // Wraps over the row
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/rram_pkg.sv
`default_nettype none

`include "rram_params.svh"

package rram_pkg;

    // Top nibble of an instruction
    typedef enum logic [3:0] {
        STORE_RRAM      = 4'b0100,
        READ_RRAM       = 4'b0101,
        HAM_SEG_COMPUTE = 4'b0111
    } instr_code_e;

    // Low-level crossbar command, registered in the sequencer
    typedef enum logic [3:0] {
        CMD_IDLE,
        CMD_WRITE_WEIGHTS,   // Load weight and column-select registers
        CMD_PROGRAM,         // Drive program pulse on one WL
        CMD_READ_SINGLE,     // Sample one column per ADC into result store
        CMD_READ_ADC_OUT,    // Pack stored results onto dout
        CMD_WRITE_INPUTS,    // Load WL input register
        CMD_COMPUTE,         // Segment MVM, add into accumulators
        CMD_READ_ACC_OUT     // Pack accumulators onto dout
    } local_cmd_e;

    typedef struct packed {
        instr_code_e code;
        logic [15:0] opcode;
    } instr_t;

    typedef logic [`RRAM_DATA_W-1:0]                  word_t;
    typedef logic [2:0]                               line_drive_t;   // {ref, minus, plus}
    typedef logic [`RRAM_THERM_W-1:0]                 therm_t;
    typedef logic [`RRAM_ADC_W-1:0]                   adc_code_t;
    typedef logic [`RRAM_ACC_W-1:0]                   acc_t;
    typedef logic [$clog2(`RRAM_NUM_WL)-1:0]          wl_addr_t;
    typedef logic [$clog2(`RRAM_COLS_PER_ADC)-1:0]    col_offset_t;
    typedef logic [$clog2(`RRAM_NUM_SL)-1:0]          col_start_t;
    // Index of a 32-bit result word within one row
    typedef logic [$clog2(`RRAM_NUM_SL*`RRAM_ADC_W/`RRAM_DATA_W)-1:0] read_index_t;

endpackage

`default_nettype wire

//--- include/rram_params.svh
`ifndef RRAM_PARAMS_SVH
`define RRAM_PARAMS_SVH

// Crossbar geometry, reduced for simulation
`define RRAM_NUM_WL        128   // Word lines
`define RRAM_NUM_SL        128   // Columns, one BL/SL pair each
`define RRAM_NUM_ADC       8     // Shared ADCs, one per class
`define RRAM_COLS_PER_ADC  16    // Columns behind each ADC mux

// Stream and datapath widths
`define RRAM_DATA_W        32    // Data-in and data-out word
`define RRAM_THERM_W       15    // Raw thermometer code
`define RRAM_ADC_W         4     // Binary ADC value
`define RRAM_ACC_W         16    // Partial-distance accumulator

// Program pulse pairs per stored word, each pair is one + and one - polarity cycle
`define RRAM_WRITE_PULSES  4

`endif
